/* include/sine_table.svh */
/* Quarter-wave sine, 256*sin(k*2*pi/256) rounded to nearest for k = 0..64.
   Included inside a module body; other quadrants come from symmetry. */

`ifndef SINE_TABLE_SVH
`define SINE_TABLE_SVH

localparam logic [8:0] SINE_TABLE [0:64] = '{
      9'd0,   9'd6,  9'd13,  9'd19,  9'd25,  9'd31,  9'd38,  9'd44,
     9'd50,  9'd56,  9'd62,  9'd68,  9'd74,  9'd80,  9'd86,  9'd92,
     9'd98, 9'd104, 9'd109, 9'd115, 9'd121, 9'd126, 9'd132, 9'd137,
    9'd142, 9'd147, 9'd152, 9'd157, 9'd162, 9'd167, 9'd172, 9'd177,
    9'd181, 9'd185, 9'd190, 9'd194, 9'd198, 9'd202, 9'd206, 9'd209,
    9'd213, 9'd216, 9'd220, 9'd223, 9'd226, 9'd229, 9'd231, 9'd234,
    9'd237, 9'd239, 9'd241, 9'd243, 9'd245, 9'd247, 9'd248, 9'd250,
    9'd251, 9'd252, 9'd253, 9'd254, 9'd255, 9'd255, 9'd256, 9'd256,
    9'd256
};

`endif

/* hdl/shape_pkg.sv */
/* Shared types and constants for the rotating triangle.
   Vertices are relative to the triangle origin, the offset puts that origin
   in the middle of a 320x180 framebuffer. */

package shape_pkg;

    // coordinates
    localparam int CORDW = 16;
    typedef logic signed [CORDW-1:0] coord_t;

    // angles, 256 steps per turn
    localparam int ANGLEW = 8;
    typedef logic [ANGLEW-1:0] angle_t;

    localparam int SINE_FRAC = 8;            // sine is scaled by 256

    localparam angle_t ANGLE_STEP = 8'd2;    // per button release

    // unrotated triangle
    localparam coord_t V0_X = 16'sd0;
    localparam coord_t V0_Y = -16'sd40;
    localparam coord_t V1_X = -16'sd30;
    localparam coord_t V1_Y = 16'sd20;
    localparam coord_t V2_X = 16'sd45;
    localparam coord_t V2_Y = 16'sd70;

    // applied after rotation
    localparam coord_t OFFS_X = 16'sd160;
    localparam coord_t OFFS_Y = 16'sd90;

endpackage

/* hdl/debounce.sv */
/* Button filter: a new level needs DEBOUNCE_CYCLES equal samples in a row.
   release_pulse fires one cycle after a 1-to-0 change is accepted. */

`timescale 1ns/1ps

module debounce #(
    parameter int DEBOUNCE_CYCLES = 100000
) (
    input  logic clk_100m,
    input  logic rst_n,
    input  logic btn,
    output logic level,
    output logic release_pulse
);

    localparam int CNTW = $clog2(DEBOUNCE_CYCLES + 1);

    logic            btn_meta, btn_sync;  // two-flop synchronizer
    logic [CNTW-1:0] cnt;
    logic            level_q;

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            btn_meta      <= 1'b0;
            btn_sync      <= 1'b0;
            cnt           <= '0;
            level         <= 1'b0;
            level_q       <= 1'b0;
            release_pulse <= 1'b0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
            level_q  <= level;
            release_pulse <= level_q && !level;
            if (btn_sync == level) begin
                cnt <= '0;  // glitch gone, start over
            end else if (cnt == CNTW'(DEBOUNCE_CYCLES - 1)) begin
                level <= btn_sync;
                cnt   <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/rotate_xy.sv */
/* Rotates (xi, yi) about the origin, 4-cycle pipeline from start to done.
   Results are floored after the multiply and only valid while done is high.
   Accepts no new start until the current result is out. */

`timescale 1ns/1ps

module rotate_xy (
    input  logic               clk_100m,
    input  logic               rst_n,
    input  logic               start,
    input  shape_pkg::angle_t  angle,
    input  shape_pkg::coord_t  xi,
    input  shape_pkg::coord_t  yi,
    output shape_pkg::coord_t  x,
    output shape_pkg::coord_t  y,
    output logic               done
);

    `include "sine_table.svh"

    localparam int SINW  = 10;                        // +-256 signed
    localparam int PRODW = shape_pkg::CORDW + SINW;
    localparam int SUMW  = PRODW + 1;

    // signed sine from the quarter table
    function automatic logic signed [SINW-1:0] sin_of(input shape_pkg::angle_t a);
        logic [6:0] idx;
        logic [8:0] mag;
        idx = {1'b0, a[5:0]};
        mag = a[6] ? SINE_TABLE[7'd64 - idx] : SINE_TABLE[idx];  // mirror in q1, q3
        sin_of = a[7] ? -$signed({1'b0, mag}) : $signed({1'b0, mag});
    endfunction

    logic [2:0]             vld;  // stage valid flags
    shape_pkg::coord_t      xs, ys;
    logic signed [SINW-1:0] sin_r, cos_r;
    logic signed [PRODW-1:0] p_xc, p_ys, p_xs, p_yc;
    logic signed [SUMW-1:0]  sum_x, sum_y;

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            vld  <= '0;
            done <= 1'b0;
        end else begin
            vld  <= {vld[1:0], start};
            done <= vld[2];
        end
    end

    always_ff @(posedge clk_100m) begin
        // stage 1 latch operands and trig values
        xs    <= xi;
        ys    <= yi;
        sin_r <= sin_of(angle);
        cos_r <= sin_of(shape_pkg::angle_t'(angle + 8'd64));
        // stage 2
        p_xc <= xs * cos_r;
        p_ys <= ys * sin_r;
        p_xs <= xs * sin_r;
        p_yc <= ys * cos_r;
        // stage 3
        sum_x <= p_xc - p_ys;
        sum_y <= p_xs + p_yc;
        // stage 4 drop the fraction, rounds toward minus infinity
        x <= shape_pkg::coord_t'(sum_x >>> shape_pkg::SINE_FRAC);
        y <= shape_pkg::coord_t'(sum_y >>> shape_pkg::SINE_FRAC);
    end

    // caller must wait for done before the next start
    assert property (@(posedge clk_100m) disable iff (!rst_n)
        start |-> !(|vld) && !done);

endmodule

/* hdl/draw_line.sv */
/* Bresenham line walker, all octants, both endpoints drawn.
   One cycle of setup after start, then one pixel per cycle with oe high.
   Endpoints are sampled at start. */

`timescale 1ns/1ps

module draw_line (
    input  logic              clk_100m,
    input  logic              rst_n,
    input  logic              start,
    input  logic              oe,
    input  shape_pkg::coord_t x0,
    input  shape_pkg::coord_t y0,
    input  shape_pkg::coord_t x1,
    input  shape_pkg::coord_t y1,
    output shape_pkg::coord_t x,
    output shape_pkg::coord_t y,
    output logic              drawing,
    output logic              done
);

    localparam int ERRW = shape_pkg::CORDW + 3;

    typedef enum logic {IDLE, DRAW} state_t;
    state_t state;

    shape_pkg::coord_t      xe, ye;
    logic signed [ERRW-1:0] dx_in, dy_in;
    logic signed [ERRW-1:0] dx, dy;       // dy kept negative
    logic signed [ERRW-1:0] err, e2;
    logic                   x_neg, y_neg;
    logic                   step_x, step_y;
    logic                   last;

    always_comb begin
        dx_in  = x1 - x0;
        dy_in  = y1 - y0;
        e2     = err <<< 1;
        step_x = (e2 >= dy);
        step_y = (e2 <= dx);
        last   = (x == xe) && (y == ye);
    end

    assign drawing = (state == DRAW) && oe;

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: if (start) state <= DRAW;
                DRAW: if (oe && last) begin
                    state <= IDLE;
                    done  <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_100m) begin
        if (state == IDLE && start) begin  // setup
            x     <= x0;
            y     <= y0;
            xe    <= x1;
            ye    <= y1;
            x_neg <= dx_in < 0;
            y_neg <= dy_in < 0;
            dx    <= (dx_in < 0) ? -dx_in : dx_in;
            dy    <= (dy_in < 0) ? dy_in : -dy_in;
            err   <= ((dx_in < 0) ? -dx_in : dx_in) + ((dy_in < 0) ? dy_in : -dy_in);
        end else if (drawing && !last) begin
            err <= err + (step_x ? dy : '0) + (step_y ? dx : '0);
            if (step_x) x <= x_neg ? x - 1'b1 : x + 1'b1;
            if (step_y) y <= y_neg ? y - 1'b1 : y + 1'b1;
        end
    end

    assert property (@(posedge clk_100m) disable iff (!rst_n)
        start |-> state == IDLE);

    // back-pressure must not move the walker
    assert property (@(posedge clk_100m) disable iff (!rst_n)
        (state == DRAW && !oe) |=> $stable(x) && $stable(y));

endmodule

/* hdl/draw_triangle.sv */
/* Triangle outline through one line walker: v0-v1, v1-v2, v2-v0.
   Corners are drawn twice. Vertices must stay put until done. */

`timescale 1ns/1ps

module draw_triangle (
    input  logic              clk_100m,
    input  logic              rst_n,
    input  logic              start,
    input  logic              oe,
    input  shape_pkg::coord_t x0,
    input  shape_pkg::coord_t y0,
    input  shape_pkg::coord_t x1,
    input  shape_pkg::coord_t y1,
    input  shape_pkg::coord_t x2,
    input  shape_pkg::coord_t y2,
    output shape_pkg::coord_t x,
    output shape_pkg::coord_t y,
    output logic              drawing,
    output logic              done
);

    typedef enum logic [1:0] {IDLE, EDGE0, EDGE1, EDGE2} state_t;
    state_t state;

    logic              line_start, line_done;
    shape_pkg::coord_t lx0, ly0, lx1, ly1;

    // endpoints of the current edge
    always_comb begin
        case (state)
            EDGE1: begin
                lx0 = x1; ly0 = y1;
                lx1 = x2; ly1 = y2;
            end
            EDGE2: begin
                lx0 = x2; ly0 = y2;
                lx1 = x0; ly1 = y0;
            end
            default: begin
                lx0 = x0; ly0 = y0;
                lx1 = x1; ly1 = y1;
            end
        endcase
    end

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            line_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            line_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                IDLE: if (start) begin
                    state      <= EDGE0;
                    line_start <= 1'b1;
                end
                EDGE0: if (line_done) begin
                    state      <= EDGE1;
                    line_start <= 1'b1;
                end
                EDGE1: if (line_done) begin
                    state      <= EDGE2;
                    line_start <= 1'b1;
                end
                EDGE2: if (line_done) begin
                    state <= IDLE;
                    done  <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    draw_line draw_line_inst (
        .clk_100m (clk_100m),
        .rst_n    (rst_n),
        .start    (line_start),
        .oe       (oe),
        .x0       (lx0),
        .y0       (ly0),
        .x1       (lx1),
        .y1       (ly1),
        .x        (x),
        .y        (y),
        .drawing  (drawing),
        .done     (line_done)
    );

    assert property (@(posedge clk_100m) disable iff (!rst_n)
        start |-> state == IDLE);

endmodule

/* hdl/shape_sequencer.sv */
/* Angle register and per-frame control: rotate three vertices, translate,
   draw. frame_start is ignored until the previous frame is finished. */

`timescale 1ns/1ps

module shape_sequencer (
    input  logic              clk_100m,
    input  logic              rst_n,
    input  logic              frame_start,
    input  logic              inc_pulse,
    input  logic              dec_pulse,
    output logic              rot_start,
    output shape_pkg::angle_t rot_angle,
    output shape_pkg::coord_t rot_xi,
    output shape_pkg::coord_t rot_yi,
    input  shape_pkg::coord_t rot_x,
    input  shape_pkg::coord_t rot_y,
    input  logic              rot_done,
    output logic              draw_start,
    output shape_pkg::coord_t vx0,
    output shape_pkg::coord_t vy0,
    output shape_pkg::coord_t vx1,
    output shape_pkg::coord_t vy1,
    output shape_pkg::coord_t vx2,
    output shape_pkg::coord_t vy2,
    input  logic              draw_done,
    output logic              shape_done
);

    typedef enum logic [2:0] {IDLE, ROT0, ROT1, ROT2, DRAW, DONE} state_t;
    state_t state;

    shape_pkg::angle_t angle;

    assign shape_done = (state == DONE);

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            angle      <= '0;
            state      <= IDLE;
            rot_start  <= 1'b0;
            draw_start <= 1'b0;
        end else begin
            if (inc_pulse) angle <= angle + shape_pkg::ANGLE_STEP;  // inc wins
            else if (dec_pulse) angle <= angle - shape_pkg::ANGLE_STEP;

            rot_start  <= 1'b0;
            draw_start <= 1'b0;
            case (state)
                IDLE: if (frame_start) begin
                    state     <= ROT0;
                    rot_start <= 1'b1;
                end
                ROT0: if (rot_done) begin
                    state     <= ROT1;
                    rot_start <= 1'b1;
                end
                ROT1: if (rot_done) begin
                    state     <= ROT2;
                    rot_start <= 1'b1;
                end
                ROT2: if (rot_done) begin
                    state      <= DRAW;
                    draw_start <= 1'b1;
                end
                DRAW: if (draw_done) state <= DONE;
                default: state <= IDLE;  // DONE
            endcase
        end
    end

    // vertex feed and translated results
    always_ff @(posedge clk_100m) begin
        case (state)
            IDLE: if (frame_start) begin
                rot_angle <= angle;  // held for the whole frame
                rot_xi    <= shape_pkg::V0_X;
                rot_yi    <= shape_pkg::V0_Y;
            end
            ROT0: if (rot_done) begin
                vx0    <= rot_x + shape_pkg::OFFS_X;
                vy0    <= rot_y + shape_pkg::OFFS_Y;
                rot_xi <= shape_pkg::V1_X;
                rot_yi <= shape_pkg::V1_Y;
            end
            ROT1: if (rot_done) begin
                vx1    <= rot_x + shape_pkg::OFFS_X;
                vy1    <= rot_y + shape_pkg::OFFS_Y;
                rot_xi <= shape_pkg::V2_X;
                rot_yi <= shape_pkg::V2_Y;
            end
            ROT2: if (rot_done) begin
                vx2 <= rot_x + shape_pkg::OFFS_X;
                vy2 <= rot_y + shape_pkg::OFFS_Y;
            end
            default: ;
        endcase
    end

endmodule

/* hdl/shape_rotate_top.sv */
/* Rotating triangle outline as a stream of pixel writes.
   pix_we is only high while fb_busy is low, and no pixel is lost or repeated.
   DEBOUNCE_CYCLES sets the button filter length in clk_100m cycles. */

`timescale 1ns/1ps

module shape_rotate_top #(
    parameter int DEBOUNCE_CYCLES = 100000
) (
    input  logic              clk_100m,
    input  logic              rst_n,
    input  logic              frame_start,
    input  logic              btn_inc,
    input  logic              btn_dec,
    input  logic              fb_busy,
    output logic              pix_we,
    output shape_pkg::coord_t pix_x,
    output shape_pkg::coord_t pix_y,
    output logic              shape_done
);

    logic              inc_pulse, dec_pulse;
    logic              rot_start, rot_done, draw_start, draw_done;
    shape_pkg::angle_t rot_angle;
    shape_pkg::coord_t rot_xi, rot_yi, rot_x, rot_y;
    shape_pkg::coord_t vx0, vy0, vx1, vy1, vx2, vy2;

    debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) deb_inc_inst (
        .clk_100m (clk_100m), .rst_n (rst_n), .btn (btn_inc),
        .level (), .release_pulse (inc_pulse)
    );

    debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) deb_dec_inst (
        .clk_100m (clk_100m), .rst_n (rst_n), .btn (btn_dec),
        .level (), .release_pulse (dec_pulse)
    );

    shape_sequencer shape_sequencer_inst (
        .clk_100m (clk_100m), .rst_n (rst_n), .frame_start (frame_start),
        .inc_pulse (inc_pulse), .dec_pulse (dec_pulse),
        .rot_start (rot_start), .rot_angle (rot_angle),
        .rot_xi (rot_xi), .rot_yi (rot_yi), .rot_x (rot_x), .rot_y (rot_y),
        .rot_done (rot_done), .draw_start (draw_start),
        .vx0 (vx0), .vy0 (vy0), .vx1 (vx1), .vy1 (vy1), .vx2 (vx2), .vy2 (vy2),
        .draw_done (draw_done), .shape_done (shape_done)
    );

    rotate_xy rotate_xy_inst (
        .clk_100m (clk_100m), .rst_n (rst_n), .start (rot_start),
        .angle (rot_angle), .xi (rot_xi), .yi (rot_yi),
        .x (rot_x), .y (rot_y), .done (rot_done)
    );

    draw_triangle draw_triangle_inst (
        .clk_100m (clk_100m), .rst_n (rst_n), .start (draw_start),
        .oe (!fb_busy),  // walk only while the framebuffer accepts writes
        .x0 (vx0), .y0 (vy0), .x1 (vx1), .y1 (vy1), .x2 (vx2), .y2 (vy2),
        .x (pix_x), .y (pix_y), .drawing (pix_we), .done (draw_done)
    );

endmodule

/* sim/tb_shape_rotate.sv */
/* Random-stimulus testbench for shape_rotate_top with DEBOUNCE_CYCLES = 8.
   The model in here recomputes sine, rotation and Bresenham on its own.
   The run stops at the first error. */

`timescale 1ns/1ps

module tb_shape_rotate;

    localparam real PI = 3.14159265358979;
    // 14 frames of ~400 px at 25% busy plus ~250 presses of ~35 cycles, with margin
    localparam int TIMEOUT_CYCLES = 40000;
    localparam shape_pkg::angle_t WALK_TARGETS [10] = '{
        8'd250, 8'd204, 8'd160, 8'd120, 8'd76, 8'd40, 8'd6, 8'd250, 8'd24, 8'd0
    };

    logic              clk_100m;
    logic              rst_n;
    logic              frame_start;
    logic              btn_inc;
    logic              btn_dec;
    logic              fb_busy;
    logic              pix_we;
    shape_pkg::coord_t pix_x;
    shape_pkg::coord_t pix_y;
    logic              shape_done;

    shape_pkg::coord_t exp_qx[$];  // expected pixel stream
    shape_pkg::coord_t exp_qy[$];
    shape_pkg::coord_t want_x, want_y;
    shape_pkg::angle_t model_angle;
    string             test_name;
    int                pix_cnt;
    int                done_cnt;
    int                cycle_cnt;
    bit                frame_open;

    shape_rotate_top #(.DEBOUNCE_CYCLES(8)) shape_rotate_top_inst (
        .clk_100m (clk_100m), .rst_n (rst_n), .frame_start (frame_start),
        .btn_inc (btn_inc), .btn_dec (btn_dec), .fb_busy (fb_busy),
        .pix_we (pix_we), .pix_x (pix_x), .pix_y (pix_y), .shape_done (shape_done)
    );

    always #5 clk_100m = ~clk_100m;

    task automatic fail_and_stop();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_pixel(input string name, input shape_pkg::coord_t ex,
                               input shape_pkg::coord_t ey, input shape_pkg::coord_t ax,
                               input shape_pkg::coord_t ay);
        if (ex !== ax || ey !== ay) begin
            $display("Mismatch in %s: expected (%0d,%0d), actual (%0d,%0d)",
                     name, ex, ey, ax, ay);
            fail_and_stop();
        end
    endtask

    task automatic check_angle_frame(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("Mismatch in %s: expected %0d pixels, actual %0d", name, expected, actual);
            fail_and_stop();
        end
    endtask

    task automatic check_pulse(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %b, actual %b", name, expected, actual);
            fail_and_stop();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_100m);
        #1;  // inputs change just after the edge
    endtask

    function automatic int round_away(input real v);
        if (v < 0.0) return -$rtoi(-v + 0.5);
        return $rtoi(v + 0.5);
    endfunction

    // integer Bresenham, both endpoints included
    task automatic push_line(input int x0, input int y0, input int x1, input int y1);
        int dx, dy, sx, sy, err, e2, x, y;
        bit at_end;
        dx = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy = (y1 > y0) ? y0 - y1 : y1 - y0;  // negative
        sx = (x1 < x0) ? -1 : 1;
        sy = (y1 < y0) ? -1 : 1;
        err = dx + dy;
        x = x0;
        y = y0;
        at_end = 1'b0;
        while (!at_end) begin
            exp_qx.push_back(shape_pkg::coord_t'(x));
            exp_qy.push_back(shape_pkg::coord_t'(y));
            at_end = (x == x1) && (y == y1);
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y += sy;
            end
        end
    endtask

    task automatic build_frame(input shape_pkg::angle_t ang, output int count);
        int  ux[3];
        int  uy[3];
        int  vx[3];
        int  vy[3];
        real th;
        int  s;
        int  c;
        ux = '{shape_pkg::V0_X, shape_pkg::V1_X, shape_pkg::V2_X};
        uy = '{shape_pkg::V0_Y, shape_pkg::V1_Y, shape_pkg::V2_Y};
        th = 2.0 * PI * ang / 256.0;
        s = round_away(256.0 * $sin(th));
        c = round_away(256.0 * $cos(th));
        for (int i = 0; i < 3; i++) begin
            // floor after the multiply, then move to the screen middle
            vx[i] = ((ux[i] * c - uy[i] * s) >>> shape_pkg::SINE_FRAC) + shape_pkg::OFFS_X;
            vy[i] = ((ux[i] * s + uy[i] * c) >>> shape_pkg::SINE_FRAC) + shape_pkg::OFFS_Y;
        end
        exp_qx.delete();
        exp_qy.delete();
        push_line(vx[0], vy[0], vx[1], vy[1]);
        push_line(vx[1], vy[1], vx[2], vy[2]);
        push_line(vx[2], vy[2], vx[0], vy[0]);
        count = exp_qx.size();
    endtask

    task automatic run_frame(input string name, input int busy_pct, input bit extra_start);
        int expected;
        bit sent;
        test_name = name;
        build_frame(model_angle, expected);
        pix_cnt = 0;
        done_cnt = 0;
        sent = 1'b0;
        frame_open = 1'b1;
        frame_start = 1'b1;
        next_cycle();
        frame_start = 1'b0;
        while (done_cnt == 0) begin
            fb_busy = ($urandom % 100) < busy_pct;
            frame_start = extra_start && !sent && pix_cnt >= 40;  // mid-draw restart try
            if (frame_start) sent = 1'b1;
            next_cycle();
        end
        frame_start = 1'b0;
        fb_busy = 1'b0;
        repeat (30) next_cycle();  // room for stray pixels or a second done
        check_angle_frame(name, expected, pix_cnt);
        frame_open = 1'b0;
    endtask

    task automatic press_button(input bit up);
        btn_inc = up;
        btn_dec = !up;
        repeat (12 + $urandom % 6) next_cycle();
        btn_inc = 1'b0;
        btn_dec = 1'b0;
        repeat (12 + $urandom % 6) next_cycle();
        if (up)
            model_angle += shape_pkg::ANGLE_STEP;
        else
            model_angle -= shape_pkg::ANGLE_STEP;
    endtask

    // too short to pass the filter
    task automatic glitch_button();
        bit on_inc;
        on_inc = $urandom % 2;
        btn_inc = on_inc;
        btn_dec = !on_inc;
        repeat (1 + $urandom % 7) next_cycle();
        btn_inc = 1'b0;
        btn_dec = 1'b0;
        repeat (12) next_cycle();
    endtask

    // biased random walk, mostly toward the target
    task automatic walk_angle(input shape_pkg::angle_t target);
        shape_pkg::angle_t diff;
        bit                go_up;
        diff = target - model_angle;
        go_up = diff < 8'd128;
        while (model_angle != target) begin
            if ($urandom % 4 == 0) glitch_button();
            press_button(go_up ^ ($urandom % 6 == 0));
        end
    endtask

    // outputs are sampled mid-cycle
    always @(negedge clk_100m) begin
        if (rst_n) begin
            if (pix_we) begin
                if (fb_busy) begin
                    $display("Pixel written in %s while fb_busy was high", test_name);
                    fail_and_stop();
                end else if (exp_qx.size() == 0) begin
                    $display("Pixel (%0d,%0d) in %s with no pixel left in the model",
                             pix_x, pix_y, test_name);
                    fail_and_stop();
                end else begin
                    want_x = exp_qx.pop_front();
                    want_y = exp_qy.pop_front();
                    check_pixel(test_name, want_x, want_y, pix_x, pix_y);
                    pix_cnt++;
                end
            end
            if (shape_done) begin
                check_pulse(test_name, frame_open && exp_qx.size() == 0 && done_cnt == 0,
                            shape_done);
                done_cnt++;
            end
        end
    end

    always @(posedge clk_100m) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles in %s", TIMEOUT_CYCLES, test_name);
            fail_and_stop();
        end
    end

    initial begin
        void'($urandom(57));
        clk_100m = 1'b0;
        rst_n = 1'b0;
        frame_start = 1'b0;
        btn_inc = 1'b0;
        btn_dec = 1'b0;
        fb_busy = 1'b0;
        model_angle = '0;
        cycle_cnt = 0;
        frame_open = 1'b0;
        test_name = "reset";
        repeat (16) @(posedge clk_100m);
        #1;
        rst_n = 1'b1;
        repeat (50) begin
            @(negedge clk_100m);
            check_pulse("reset pix_we", 1'b0, pix_we);
            check_pulse("reset shape_done", 1'b0, shape_done);
        end
        next_cycle();

        run_frame("angle 0", 0, 1'b0);
        run_frame("back-pressure", 25, 1'b0);
        run_frame("back-pressure", 25, 1'b0);

        for (int i = 0; i < 10; i++) begin
            walk_angle(WALK_TARGETS[i]);
            repeat (10) next_cycle();  // last release reaches the angle register
            run_frame("buttons", 25, 1'b0);
        end

        run_frame("frame_start while busy", 25, 1'b1);

        $display("Everything OK");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
hdl/shape_pkg.sv
hdl/debounce.sv
hdl/rotate_xy.sv
hdl/draw_line.sv
hdl/draw_triangle.sv
hdl/shape_sequencer.sv
hdl/shape_rotate_top.sv
sim/tb_shape_rotate.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result from the log file.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_shape_rotate -o tb_shape_rotate

# the simulator exits non-zero on $fatal, the log decides
./obj_dir/tb_shape_rotate > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
